/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_soc_dev
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# A run that stops early never prints the pass line, so that counts as failure too
run: compile
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/baud_timer.sv */
`timescale 1ns/1ps

module baud_timer #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic start_i,   // Realigns the bit period
    input  logic run_i,     // Frame in progress
    output logic tick_o
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    logic [CNT_W-1:0] cnt;
    logic             last;  // Final cycle of the bit

    assign last = (cnt == CNT_W'(CLKS_PER_BIT - 1));

    // ------------------------------
    // Bit-period counter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || start_i) begin
            cnt <= '0;
        end else if (run_i) begin
            cnt <= last ? '0 : cnt + CNT_W'(1);  // Wraps every bit
        end
    end

    assign tick_o = run_i && last;   // One pulse per bit

endmodule

/* design/dev_decoder.sv */
`timescale 1ns/1ps
`include "soc_dev_defines.svh"

module dev_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  soc_dev_pkg::dev_req_t  bus_req_i,
    output soc_dev_pkg::dev_rsp_t  bus_rsp_o,
    output logic                   uart_stb_o,
    output logic                   uart_we_o,
    output soc_dev_pkg::uart_reg_e uart_reg_o,
    output logic [`XLEN/8-1:0]     uart_be_o,
    output logic [`XLEN-1:0]       uart_wdata_o,
    input  logic                   uart_ready_i,
    input  logic [`XLEN-1:0]       uart_rdata_i
);

    soc_dev_pkg::dev_sel_e sel;
    logic                  none_rdy;   // Unmapped responder pulse

    // ------------------------------
    // Address decode
    // ------------------------------
    assign sel = (bus_req_i.addr[`XLEN-1 -: `DEV_PAGE_W] == `UART_PAGE) ?
                 soc_dev_pkg::SEL_UART : soc_dev_pkg::SEL_NONE;

    // Strobe only reaches the selected device
    assign uart_stb_o   = bus_req_i.strobe && (sel == soc_dev_pkg::SEL_UART);
    assign uart_we_o    = bus_req_i.we;
    assign uart_reg_o   = soc_dev_pkg::uart_reg_e'(bus_req_i.addr[3:2]); // Word offset
    assign uart_be_o    = bus_req_i.be;
    assign uart_wdata_o = bus_req_i.wdata;

    // ------------------------------
    // Unmapped responder
    // ------------------------------
    // Answers one cycle later so the bus never hangs
    always_ff @(posedge clk) begin
        if (rst) begin
            none_rdy <= 1'b0;
        end else begin
            none_rdy <= bus_req_i.strobe && (sel == soc_dev_pkg::SEL_NONE);
        end
    end

    // At most one responder pulses since one access is in flight
    assign bus_rsp_o.ready = uart_ready_i | none_rdy;
    assign bus_rsp_o.rdata = none_rdy ? '0 : uart_rdata_i;   // Zero data when unmapped

endmodule

/* design/device_arbiter.sv */
`timescale 1ns/1ps
`include "soc_dev_defines.svh"

module device_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  soc_dev_pkg::dev_req_t m_req_i [`NUM_MASTERS],
    output soc_dev_pkg::dev_rsp_t m_rsp_o [`NUM_MASTERS],
    output soc_dev_pkg::dev_req_t dev_req_o,
    input  soc_dev_pkg::dev_rsp_t dev_rsp_i
);

    localparam int IDX_W = (`NUM_MASTERS > 1) ? $clog2(`NUM_MASTERS) : 1;

    soc_dev_pkg::arb_state_e state;
    soc_dev_pkg::dev_req_t   pend_req [`NUM_MASTERS]; // Captured request fields
    logic [`NUM_MASTERS-1:0] pend_vld;                // Slot holds an open request
    logic [IDX_W-1:0]        last_grant;              // Also the bus owner while busy
    logic [IDX_W-1:0]        grant_idx;               // Round-robin winner
    logic [IDX_W-1:0]        cand;
    logic                    grant_vld;
    logic                    issue;                   // Downstream strobe
    logic                    done;                    // Device answered the owner

    // ------------------------------
    // Pending slots
    // ------------------------------
    // Masters drop their fields after the strobe so take a copy here
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            if (m_req_i[i].strobe) begin
                pend_req[i] <= m_req_i[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_vld <= '0;
        end else begin
            for (int i = 0; i < `NUM_MASTERS; i++) begin
                if (m_req_i[i].strobe) begin
                    pend_vld[i] <= 1'b1;
                end else if (done && (last_grant == IDX_W'(i))) begin
                    pend_vld[i] <= 1'b0;                 // Retired at its ready
                end
            end
        end
    end

    // ------------------------------
    // Round-robin pick
    // ------------------------------
    // Search starts just after the last granted master
    always_comb begin
        grant_vld = 1'b0;
        grant_idx = last_grant;
        cand      = last_grant;
        for (int k = 1; k <= `NUM_MASTERS; k++) begin
            cand = IDX_W'((int'(last_grant) + k) % `NUM_MASTERS);
            if (!grant_vld && pend_vld[cand]) begin
                grant_vld = 1'b1;
                grant_idx = cand;
            end
        end
    end

    assign issue = (state == soc_dev_pkg::ARB_IDLE) && grant_vld;
    assign done  = (state == soc_dev_pkg::ARB_BUSY) && dev_rsp_i.ready;

    // ------------------------------
    // FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= soc_dev_pkg::ARB_IDLE;
            last_grant <= IDX_W'(`NUM_MASTERS - 1);      // Master 0 goes first
        end else begin
            case (state)
                soc_dev_pkg::ARB_IDLE: begin
                    if (issue) begin
                        state      <= soc_dev_pkg::ARB_BUSY;
                        last_grant <= grant_idx;
                    end
                end
                soc_dev_pkg::ARB_BUSY: begin
                    if (done) begin
                        state <= soc_dev_pkg::ARB_IDLE;  // Only one access in flight
                    end
                end
                default: state <= soc_dev_pkg::ARB_IDLE;
            endcase
        end
    end

    // Fields are only looked at together with the strobe
    always_comb begin
        dev_req_o        = pend_req[grant_idx];
        dev_req_o.strobe = issue;
    end

    // Ready goes straight back to the owner in the same cycle
    always_comb begin
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            m_rsp_o[i].ready = done && (last_grant == IDX_W'(i));
            m_rsp_o[i].rdata = dev_rsp_i.rdata;
        end
    end

endmodule

/* design/soc_dev_pkg.sv */
`include "soc_dev_defines.svh"

package soc_dev_pkg;

    // ------------------------------
    // Device bus
    // ------------------------------
    // Request from a master, or from the arbiter to the decoder
    typedef struct packed {
        logic                 strobe;  // One-cycle pulse
        logic [`XLEN-1:0]     addr;
        logic                 we;      // 1 = write
        logic [`XLEN/8-1:0]   be;      // Byte enables
        logic [`XLEN-1:0]     wdata;
    } dev_req_t;

    // Response back toward a master
    typedef struct packed {
        logic                 ready;   // One-cycle pulse
        logic [`XLEN-1:0]     rdata;   // Valid only with ready
    } dev_rsp_t;

    // ------------------------------
    // Enums
    // ------------------------------
    typedef enum logic {
        ARB_IDLE,                      // Waiting for a pending master
        ARB_BUSY                       // One access in flight
    } arb_state_e;

    typedef enum logic [1:0] {
        REG_DATA = `UART_REG_DATA,     // Tx byte, reads back last accepted byte
        REG_STAT = `UART_REG_STAT      // Bit 0 is busy
    } uart_reg_e;

    typedef enum logic {
        SEL_UART,
        SEL_NONE                       // Unmapped page
    } dev_sel_e;

endpackage

/* design/soc_dev_top.sv */
`timescale 1ns/1ps
`include "soc_dev_defines.svh"

module soc_dev_top (
    input  logic                  clk,
    input  logic                  usr_reset,
    input  soc_dev_pkg::dev_req_t m_req_i [`NUM_MASTERS],
    output soc_dev_pkg::dev_rsp_t m_rsp_o [`NUM_MASTERS],
    output logic                  uart_tx_o
);

    logic [`RST_STRETCH-1:0] rst_sr;      // Reset stretch shift register
    logic                    rst;         // Internal reset, last stage

    soc_dev_pkg::dev_req_t   bus_req;     // Arbiter to decoder
    soc_dev_pkg::dev_rsp_t   bus_rsp;     // Decoder to arbiter

    logic                    uart_stb;
    logic                    uart_we;
    soc_dev_pkg::uart_reg_e  uart_reg;
    logic [`XLEN/8-1:0]      uart_be;
    logic [`XLEN-1:0]        uart_wdata;
    logic                    uart_ready;
    logic [`XLEN-1:0]        uart_rdata;

    // ------------------------------
    // Reset stretcher
    // ------------------------------
    // Ones fill in while usr_reset is held, zeros shift in after it drops
    always_ff @(posedge clk) begin
        if (usr_reset) begin
            rst_sr <= '1;
        end else begin
            rst_sr <= {rst_sr[`RST_STRETCH-2:0], 1'b0};
        end
    end

    assign rst = rst_sr[`RST_STRETCH-1];

    // ------------------------------
    // Device path
    // ------------------------------
    device_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .m_req_i   (m_req_i),
        .m_rsp_o   (m_rsp_o),
        .dev_req_o (bus_req),
        .dev_rsp_i (bus_rsp)
    );

    dev_decoder u_dec (
        .clk          (clk),
        .rst          (rst),
        .bus_req_i    (bus_req),
        .bus_rsp_o    (bus_rsp),
        .uart_stb_o   (uart_stb),
        .uart_we_o    (uart_we),
        .uart_reg_o   (uart_reg),
        .uart_be_o    (uart_be),
        .uart_wdata_o (uart_wdata),
        .uart_ready_i (uart_ready),
        .uart_rdata_i (uart_rdata)
    );

    uart_tx_dev u_uart (
        .clk       (clk),
        .rst       (rst),
        .stb_i     (uart_stb),
        .we_i      (uart_we),
        .reg_i     (uart_reg),
        .be_i      (uart_be),
        .wdata_i   (uart_wdata),
        .ready_o   (uart_ready),
        .rdata_o   (uart_rdata),
        .uart_tx_o (uart_tx_o)
    );

endmodule

/* design/uart_tx_dev.sv */
`timescale 1ns/1ps
`include "soc_dev_defines.svh"

module uart_tx_dev (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stb_i,
    input  logic                   we_i,
    input  soc_dev_pkg::uart_reg_e reg_i,
    input  logic [`XLEN/8-1:0]     be_i,
    input  logic [`XLEN-1:0]       wdata_i,
    output logic                   ready_o,
    output logic [`XLEN-1:0]       rdata_o,
    output logic                   uart_tx_o
);

    localparam int FRAME_BITS = 10;   // Start, 8 data, stop

    logic [7:0]            data_byte;  // Last accepted byte
    logic [FRAME_BITS-1:0] frame;      // LSB is the line level
    logic [3:0]            bit_cnt;    // Bits already sent
    logic                  busy;
    logic                  load;       // Accepted write to REG_DATA
    logic                  tick;       // End of a bit period

    assign load = stb_i && we_i && (reg_i == soc_dev_pkg::REG_DATA) && be_i[0] && !busy;

    // ------------------------------
    // Bus side
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ready_o <= 1'b0;
        end else begin
            ready_o <= stb_i;            // Every access answered next cycle
        end
    end

    // Writes also get a value here, the master ignores it
    always_ff @(posedge clk) begin
        if (stb_i) begin
            if (reg_i == soc_dev_pkg::REG_STAT) begin
                rdata_o <= {{(`XLEN-1){1'b0}}, busy};
            end else begin
                rdata_o <= {{(`XLEN-8){1'b0}}, data_byte};
            end
        end
    end

    // ------------------------------
    // Frame shifter
    // ------------------------------
    always_ff @(posedge clk) begin
        if (load) begin
            data_byte <= wdata_i[7:0];
            frame     <= {1'b1, wdata_i[7:0], 1'b0};    // Stop, data LSB first, start
        end else if (tick) begin
            frame     <= {1'b1, frame[FRAME_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
        end else if (load) begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end else if (tick) begin
            if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                busy <= 1'b0;                           // Stop bit done
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end
    end

    assign uart_tx_o = busy ? frame[0] : 1'b1;          // Line idles high

    baud_timer #(
        .CLKS_PER_BIT (`UART_CLKS_PER_BIT)
    ) u_baud (
        .clk     (clk),
        .rst     (rst),
        .start_i (load),
        .run_i   (busy),
        .tick_o  (tick)
    );

endmodule

/* flist.f */
+incdir+include
design/soc_dev_pkg.sv
design/baud_timer.sv
design/uart_tx_dev.sv
design/dev_decoder.sv
design/device_arbiter.sv
design/soc_dev_top.sv
tests/soc_dev_chk.sv
tests/tb_soc_dev.sv

/* include/soc_dev_defines.svh */
`ifndef SOC_DEV_DEFINES_SVH
`define SOC_DEV_DEFINES_SVH

// ------------------------------
// Bus geometry
// ------------------------------
`define XLEN              32      // Data and address width
`define NUM_MASTERS       2       // Core-side master ports

// ------------------------------
// Device map
// ------------------------------
`define DEV_PAGE_W        8       // Top address byte picks the device
`define UART_PAGE         8'hC0   // 0xC000_0000 .. 0xC0FF_FFFF

// UART register word offsets within its page
`define UART_REG_DATA     0
`define UART_REG_STAT     1

// ------------------------------
// Timing
// ------------------------------
`define RST_STRETCH       5       // Cycles rst outlasts usr_reset
`define UART_CLKS_PER_BIT 16      // Short bit period for simulation

`endif

/* tests/soc_dev_chk.sv */
`timescale 1ns/1ps
`include "soc_dev_defines.svh"

module soc_dev_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    dn_stb_i,    // Arbiter to decoder strobe
    input logic                    arb_idle_i,
    input logic [`NUM_MASTERS-1:0] pend_i,      // Arbiter pending slots
    input logic                    m0_stb_i,
    input logic                    m1_stb_i,
    input logic                    m0_rdy_i,
    input logic                    m1_rdy_i,
    input logic                    busy_i,      // UART frame in progress
    input logic                    tx_i
);

    // ------------------------------
    // Bus protocol
    // ------------------------------
    a_dn_stb_pulse: assert property (@(posedge clk) disable iff (rst)
        dn_stb_i |=> !dn_stb_i)
        else $error("Downstream strobe held longer than one cycle");

    a_rdy_apart: assert property (@(posedge clk) disable iff (rst)
        !(m0_rdy_i && m1_rdy_i))
        else $error("Both masters got ready in the same cycle");

    // Nothing else pending and arbiter idle, so the answer is fixed at 2 cycles
    a_m0_lat: assert property (@(posedge clk) disable iff (rst)
        m0_stb_i && !m1_stb_i && arb_idle_i && (pend_i == '0) |-> ##2 m0_rdy_i)
        else $error("Uncontended master 0 access not answered after 2 cycles");

    a_m1_lat: assert property (@(posedge clk) disable iff (rst)
        m1_stb_i && !m0_stb_i && arb_idle_i && (pend_i == '0) |-> ##2 m1_rdy_i)
        else $error("Uncontended master 1 access not answered after 2 cycles");

    // ------------------------------
    // Serial line
    // ------------------------------
    a_tx_idle: assert property (@(posedge clk) disable iff (rst)
        !busy_i |-> tx_i)
        else $error("Serial line low while the UART is idle");

endmodule

bind device_arbiter soc_dev_chk u_arb_chk (
    .clk        (clk),
    .rst        (rst),
    .dn_stb_i   (dev_req_o.strobe),
    .arb_idle_i (state == soc_dev_pkg::ARB_IDLE),
    .pend_i     (pend_vld),
    .m0_stb_i   (m_req_i[0].strobe),
    .m1_stb_i   (m_req_i[1].strobe),
    .m0_rdy_i   (m_rsp_o[0].ready),
    .m1_rdy_i   (m_rsp_o[1].ready),
    .busy_i     (1'b0),
    .tx_i       (1'b1)
);

bind uart_tx_dev soc_dev_chk u_uart_chk (
    .clk        (clk),
    .rst        (rst),
    .dn_stb_i   (1'b0),
    .arb_idle_i (1'b1),
    .pend_i     ('0),
    .m0_stb_i   (1'b0),
    .m1_stb_i   (1'b0),
    .m0_rdy_i   (1'b0),
    .m1_rdy_i   (1'b0),
    .busy_i     (busy),
    .tx_i       (uart_tx_o)
);

/* tests/soc_dev_stim.txt */
# master(0, 1 or B for both) op(R/W) addr wdata exp_rdata serial
# serial on W: byte must appear on the line; on R: wait for pending frames first
B R C0000004 00000000 00000000 0
0 W C0000000 000000A5 00000000 1
0 R C0000004 00000000 00000001 0
1 R C0000000 00000000 000000A5 0
1 R C0000004 00000000 00000000 1
1 W C0000000 0000003C 00000000 1
0 W C0000000 000000C3 00000000 0
B R C0000000 00000000 0000003C 0
0 R C0000004 00000000 00000000 1
0 R C0000000 00000000 0000003C 0
B R 10000000 00000000 00000000 0
1 W 20000040 DEADBEEF 00000000 0
0 R 40000000 00000000 00000000 0
B W C0000000 00000081 00000000 1
1 R C0000000 00000000 00000081 1
0 R C0000004 00000000 00000000 0

/* tests/tb_soc_dev.sv */
`timescale 1ns/1ps
`include "soc_dev_defines.svh"

module tb_soc_dev;

    localparam int CPB         = `UART_CLKS_PER_BIT;
    localparam int ACC_TIMEOUT = 50;          // Cycles allowed for a ready
    localparam int RX_TIMEOUT  = 20 * CPB;    // Cycles allowed for a frame

    logic                  clk;
    logic                  usr_reset;
    soc_dev_pkg::dev_req_t m_req [`NUM_MASTERS];
    soc_dev_pkg::dev_rsp_t m_rsp [`NUM_MASTERS];
    logic                  uart_tx;

    int          errors;
    int          checks;
    int          cyc = 0;       // Rising edge count
    int          last_grant;    // Round-robin pointer model
    logic [31:0] rng;
    logic [7:0]  exp_q [$];     // Bytes owed on the serial line
    logic [7:0]  rx_q [$];      // Bytes decoded by the monitor

    soc_dev_top DUT (
        .clk       (clk),
        .usr_reset (usr_reset),
        .m_req_i   (m_req),
        .m_rsp_o   (m_rsp),
        .uart_tx_o (uart_tx)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;       // 10 ns period

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ------------------------------
    // Serial monitor
    // ------------------------------
    // Start edge found on a falling clock, then every bit sampled at its centre
    initial begin
        logic [7:0] b;
        forever begin
            @(negedge clk);
            if (!usr_reset && uart_tx === 1'b0) begin
                repeat (CPB / 2) @(negedge clk);
                if (uart_tx === 1'b0) begin                  // Real start bit
                    for (int i = 0; i < 8; i++) begin
                        repeat (CPB) @(negedge clk);
                        b[i] = uart_tx;                       // LSB first
                    end
                    repeat (CPB) @(negedge clk);
                    checks++;
                    assert (uart_tx === 1'b1) else begin
                        errors++;
                        $display("Fail uart_tx_o stop bit got %h expected %h", uart_tx, 1'b1);
                    end
                    rx_q.push_back(b);
                end
            end
        end
    end

    // One access on master idx, strobe already aligned 1 ns after an edge
    task automatic do_access(input int idx, input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp_rdata,
                             output int rdy_cyc, output int lat);
        int   n;
        logic got;
        m_req[idx] = '{strobe: 1'b1, addr: addr, we: we, be: 4'hF, wdata: wdata};
        @(posedge clk);
        #1;
        m_req[idx] = '0;                                      // Strobe lasts one cycle
        n   = 1;
        got = 1'b0;
        while (!got && n <= ACC_TIMEOUT) begin
            @(negedge clk);
            if (m_rsp[idx].ready) begin
                got = 1'b1;
            end else begin
                n++;
            end
        end
        rdy_cyc = cyc;
        lat     = n;                                          // Cycles after the strobe
        checks++;
        assert (got) else begin
            errors++;
            $display("No ready for master %0d within %0d cycles", idx, ACC_TIMEOUT);
        end
        if (got && !we) begin
            checks++;
            assert (m_rsp[idx].rdata == exp_rdata) else begin
                errors++;
                $display("Fail m_rsp[%0d].rdata got %h expected %h",
                         idx, m_rsp[idx].rdata, exp_rdata);
            end
        end
    endtask

    // Compares every owed byte with the decoded ones, then lets the stop bit end
    task automatic drain_serial();
        int         n;
        logic [7:0] e;
        logic [7:0] r;
        while (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            n = 0;
            while (rx_q.size() == 0 && n < RX_TIMEOUT) begin
                @(negedge clk);
                n++;
            end
            checks++;
            assert (rx_q.size() > 0) else begin
                errors++;
                $display("No serial frame decoded for byte %h", e);
            end
            if (rx_q.size() > 0) begin
                r = rx_q.pop_front();
                checks++;
                assert (r == e) else begin
                    errors++;
                    $display("Fail uart_tx_o byte got %h expected %h", r, e);
                end
            end
        end
        repeat (CPB) @(negedge clk);                          // busy drops after the stop bit
    endtask

    // ------------------------------
    // One stimulus line
    // ------------------------------
    task automatic run_line(input logic [7:0] m_tok, input logic [7:0] op_tok,
                            input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [31:0] exp_rdata, input int ser);
        int   rc0;
        int   rc1;
        int   lat0;
        int   lat1;
        int   first;
        int   idx;
        logic we;
        we = (op_tok == "W");
        if (!we && ser != 0) begin
            drain_serial();
        end
        rng = xorshift32(rng);
        repeat (rng % 4) @(posedge clk);                      // Random idle gap
        @(posedge clk);
        #1;
        if (m_tok == "B") begin
            first = (last_grant + 1) % `NUM_MASTERS;          // Not granted last wins
            fork
                do_access(0, we, addr, wdata, exp_rdata, rc0, lat0);
                do_access(1, we, addr, wdata, exp_rdata, rc1, lat1);
            join
            checks++;
            assert (rc0 != rc1) else begin
                errors++;
                $display("Both masters were answered in the same cycle");
            end
            checks++;
            assert ((first == 0) ? (rc0 < rc1) : (rc1 < rc0)) else begin
                errors++;
                $display("Master %0d was not served first", first);
            end
            checks++;
            assert (((first == 0) ? lat0 : lat1) == 2) else begin
                errors++;
                $display("Fail m_rsp[%0d].ready latency got %h expected %h",
                         first, (first == 0) ? lat0 : lat1, 2);
            end
            last_grant = 1 - first;                           // Loser goes second
        end else begin
            idx = (m_tok == "1") ? 1 : 0;
            do_access(idx, we, addr, wdata, exp_rdata, rc0, lat0);
            checks++;
            assert (lat0 == 2) else begin
                errors++;
                $display("Fail m_rsp[%0d].ready latency got %h expected %h", idx, lat0, 2);
            end
            last_grant = idx;
        end
        if (we && ser != 0) begin
            exp_q.push_back(wdata[7:0]);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int          fd;
        int          code;
        int          c;
        int          ser;
        logic [7:0]  m_tok;
        logic [7:0]  op_tok;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        errors     = 0;
        checks     = 0;
        last_grant = 1;                                       // Master 0 first after reset
        rng        = 32'h4384_e1ba;
        usr_reset  = 1'b1;
        for (int i = 0; i < `NUM_MASTERS; i++) begin
            m_req[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        usr_reset = 1'b0;

        // Quiet bus and idle line through the reset stretch
        for (int k = 0; k < 12; k++) begin
            @(negedge clk);
            checks++;
            assert (!m_rsp[0].ready) else begin
                errors++;
                $display("Fail m_rsp[0].ready got %h expected %h", m_rsp[0].ready, 1'b0);
            end
            checks++;
            assert (!m_rsp[1].ready) else begin
                errors++;
                $display("Fail m_rsp[1].ready got %h expected %h", m_rsp[1].ready, 1'b0);
            end
            checks++;
            assert (uart_tx == 1'b1) else begin
                errors++;
                $display("Fail uart_tx_o got %h expected %h", uart_tx, 1'b1);
            end
        end

        fd = $fopen("tests/soc_dev_stim.txt", "r");
        checks++;
        assert (fd != 0) else begin
            errors++;
            $display("Cannot open the stimulus file");
        end
        if (fd != 0) begin
            code = $fscanf(fd, " %c", m_tok);
            while (code == 1) begin
                if (m_tok == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin                 // Skip to end of line
                        c = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, " %c %h %h %h %d", op_tok, addr, wdata, exp_rdata, ser);
                    checks++;
                    assert (code == 5) else begin
                        errors++;
                        $display("Malformed line in the stimulus file");
                    end
                    if (code == 5) begin
                        run_line(m_tok, op_tok, addr, wdata, exp_rdata, ser);
                    end
                end
                code = $fscanf(fd, " %c", m_tok);
            end
            $fclose(fd);
        end

        drain_serial();
        repeat (12 * CPB) @(negedge clk);                     // Room for a stray frame
        checks++;
        assert (rx_q.size() == 0) else begin
            errors++;
            $display("Serial line carried %0d unexpected frame(s)", rx_q.size());
        end

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
